// File: verilog/umi_pkg.sv
`default_nettype none

package umi_pkg;

   //############################
   // widths and geometry
   //############################

   localparam int ADDR_W    = 32;                 // byte address
   localparam int DATA_W    = 32;                 // one word per packet
   localparam int NUM_BANKS = 4;                  // endpoints behind the router
   localparam int BANK_W    = $clog2(NUM_BANKS);  // bank select bits
   localparam int WORDS     = 16;                 // words per bank
   localparam int WORD_W    = $clog2(WORDS);      // word select bits

   // address slicing, word aligned
   localparam int WORD_LSB  = 2;                  // bits [1:0] are the byte lane
   localparam int BANK_LSB  = WORD_LSB + WORD_W;  // bank sits right above the word

   //############################
   // command codes
   //############################

   localparam logic [6:0] CMD_READ  = 7'h01;      // read request
   localparam logic [6:0] CMD_WRITE = 7'h03;      // posted write
   localparam logic [6:0] CMD_RESP  = 7'h02;      // read response

   //############################
   // field types
   //############################

   typedef logic [ADDR_W-1:0] umi_addr_t;
   typedef logic [DATA_W-1:0] umi_data_t;
   typedef logic [6:0]        umi_cmd_t;
   typedef logic [3:0]        umi_size_t;         // carried, not decoded
   typedef logic [19:0]       umi_opt_t;          // carried, not decoded
   typedef logic [BANK_W-1:0] bank_idx_t;
   typedef logic [WORD_W-1:0] word_idx_t;

   // one packet on any channel, msb first
   typedef struct packed {
      umi_cmd_t  cmd;
      umi_size_t size;
      umi_opt_t  options;
      umi_addr_t dstaddr;     // target byte address
      umi_addr_t srcaddr;     // where a response goes
      umi_data_t data;
   } umi_packet_t;

   // router round robin, remembers who won last
   typedef enum logic {
      LAST_WR,
      LAST_RD
   } arb_state_t;

endpackage

`default_nettype wire

// File: verilog/umi_req_router.sv
`timescale 1ns/1ps
`default_nettype none

module umi_req_router
   (
   input  logic                             clk,
   input  logic                             nreset,
   // posted writes
   input  logic                             wr_valid,
   input  umi_pkg::umi_packet_t             wr_packet,
   output logic                             wr_ready,
   // read requests
   input  logic                             req_valid,
   input  umi_pkg::umi_packet_t             req_packet,
   output logic                             req_ready,
   // toward the banks, packet bus is shared
   output logic [umi_pkg::NUM_BANKS-1:0]    bank_valid,
   output umi_pkg::umi_packet_t             bank_packet,
   input  logic [umi_pkg::NUM_BANKS-1:0]    bank_ready
   );

   import umi_pkg::*;

   arb_state_t  last_grant;     // who won last time
   logic        hold_valid;     // holding register full
   umi_packet_t hold_packet;
   bank_idx_t   hold_bank;      // decoded once, on entry
   logic        hold_take;      // target bank takes it this cycle
   logic        hold_free;      // room for a new packet
   logic        accept_wr;
   logic        accept_rd;
   umi_packet_t next_packet;

   //############################
   // arbitration
   //############################

   assign hold_take = hold_valid & bank_ready[hold_bank];
   assign hold_free = ~hold_valid | hold_take;

   // a channel loses only if the other one is waiting and it is the other's turn
   assign wr_ready = hold_free & (~req_valid | (last_grant == LAST_RD));
   assign req_ready = hold_free & (~wr_valid | (last_grant == LAST_WR));

   assign accept_wr = wr_valid & wr_ready;
   assign accept_rd = req_valid & req_ready;   // never together with accept_wr

   assign next_packet = accept_wr ? wr_packet : req_packet;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         last_grant <= LAST_RD;                // writes win first
      else if (accept_wr)
         last_grant <= LAST_WR;
      else if (accept_rd)
         last_grant <= LAST_RD;
   end

   //############################
   // holding register
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         hold_valid <= 1'b0;
      else if (accept_wr || accept_rd)
         hold_valid <= 1'b1;
      else if (hold_take)
         hold_valid <= 1'b0;
   end

   // payload, loaded on accept only
   always_ff @(posedge clk)
   begin
      if (accept_wr || accept_rd)
      begin
         hold_packet <= next_packet;
         hold_bank   <= next_packet.dstaddr[BANK_LSB +: BANK_W];   // upper bits alias
      end
   end

   //############################
   // bank select
   //############################

   assign bank_packet = hold_packet;

   always_comb
   begin
      for (int b = 0; b < NUM_BANKS; b++)
         bank_valid[b] = hold_valid && (hold_bank == bank_idx_t'(b));
   end

   // only one bank ever sees the packet
   a_bank_onehot : assert property (@(posedge clk) disable iff (!nreset)
      $onehot0(bank_valid));

   // a stalled packet must not change under the bank
   a_hold_stable : assert property (@(posedge clk) disable iff (!nreset)
      hold_valid && !hold_take |=>
         hold_valid && $stable(hold_packet) && $stable(hold_bank));

endmodule

`default_nettype wire

// File: verilog/umi_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module umi_endpoint
   (
   input  logic                 clk,
   input  logic                 nreset,
   // request from the router
   input  logic                 in_valid,
   input  umi_pkg::umi_packet_t in_packet,
   output logic                 in_ready,
   // read response toward the merger
   output logic                 out_valid,
   output umi_pkg::umi_packet_t out_packet,
   input  logic                 out_ready
   );

   import umi_pkg::*;

   umi_data_t mem [WORDS];      // local word store, starts unknown
   word_idx_t in_word;          // word index from dstaddr
   logic      is_write;
   logic      is_read;
   logic      accept;
   logic      rd_accept;

   //############################
   // decode
   //############################

   assign in_word  = in_packet.dstaddr[WORD_LSB +: WORD_W];   // byte lane ignored
   assign is_write = (in_packet.cmd == CMD_WRITE);
   assign is_read  = (in_packet.cmd == CMD_READ);
   // anything else falls through, taken but no effect

   // ready as long as the response slot is free or draining
   assign in_ready = ~out_valid | out_ready;
   assign accept   = in_valid & in_ready;

   assign rd_accept = accept & is_read;

   //############################
   // memory write
   //############################

   always_ff @(posedge clk)
   begin
      if (accept && is_write)
         mem[in_word] <= in_packet.data;
   end

   //############################
   // response register
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         out_valid <= 1'b0;
      else if (rd_accept)
         out_valid <= 1'b1;                    // back to back read reloads it
      else if (out_ready)
         out_valid <= 1'b0;
   end

   // synchronous read straight into the outgoing packet
   always_ff @(posedge clk)
   begin
      if (rd_accept)
      begin
         out_packet.cmd     <= CMD_RESP;
         out_packet.size    <= in_packet.size;        // passed through
         out_packet.options <= in_packet.options;     // passed through
         out_packet.dstaddr <= in_packet.srcaddr;     // reply goes to requester
         out_packet.srcaddr <= '0;
         out_packet.data    <= mem[in_word];
      end
   end

   // response held until the merger takes it
   a_out_stable : assert property (@(posedge clk) disable iff (!nreset)
      out_valid && !out_ready |=> out_valid && $stable(out_packet));

endmodule

`default_nettype wire

// File: verilog/umi_resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module umi_resp_merge
   (
   input  logic                             clk,
   input  logic                             nreset,
   // one response channel per bank
   input  logic [umi_pkg::NUM_BANKS-1:0]    ep_valid,
   input  umi_pkg::umi_packet_t             ep_packet [umi_pkg::NUM_BANKS],
   output logic [umi_pkg::NUM_BANKS-1:0]    ep_ready,
   // merged output
   output logic                             resp_valid,
   output umi_pkg::umi_packet_t             resp_packet,
   input  logic                             resp_ready
   );

   import umi_pkg::*;

   bank_idx_t ptr;          // highest priority bank this cycle
   bank_idx_t gnt_bank;     // bank routed to the output
   logic      gnt_found;    // some bank is valid

   //############################
   // rotating priority search
   //############################

   always_comb
   begin
      bank_idx_t idx;
      gnt_found = 1'b0;
      gnt_bank  = ptr;
      for (int k = 0; k < NUM_BANKS; k++)
      begin
         idx = ptr + bank_idx_t'(k);            // wraps in BANK_W bits
         if (!gnt_found && ep_valid[idx])
         begin
            gnt_found = 1'b1;
            gnt_bank  = idx;
         end
      end
   end

   //############################
   // output mux and ready
   //############################

   assign resp_valid  = gnt_found;
   assign resp_packet = ep_packet[gnt_bank];

   always_comb
   begin
      for (int b = 0; b < NUM_BANKS; b++)
         ep_ready[b] = gnt_found && resp_ready && (gnt_bank == bank_idx_t'(b));
   end

   // move past the winner only once it has gone out
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ptr <= '0;
      else if (resp_valid && resp_ready)
         ptr <= bank_idx_t'(gnt_bank + 1'b1);
      else if (resp_valid)
         ptr <= gnt_bank;                      // park on a stalled winner
   end

   // never drain two banks at once
   a_ready_onehot : assert property (@(posedge clk) disable iff (!nreset)
      $onehot0(ep_ready));

   // a stalled output keeps its grant, banks hold their packets meanwhile
   a_grant_held : assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(gnt_bank));

endmodule

`default_nettype wire

// File: verilog/umi_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module umi_mem_top
   (
   input  logic                 clk,
   input  logic                 nreset,
   // posted writes
   input  logic                 wr_valid,
   input  umi_pkg::umi_packet_t wr_packet,
   output logic                 wr_ready,
   // read requests
   input  logic                 req_valid,
   input  umi_pkg::umi_packet_t req_packet,
   output logic                 req_ready,
   // read responses
   output logic                 resp_valid,
   output umi_pkg::umi_packet_t resp_packet,
   input  logic                 resp_ready
   );

   import umi_pkg::*;

   // router to banks
   logic [NUM_BANKS-1:0] bank_valid;
   umi_packet_t          bank_packet;   // shared, valid selects
   logic [NUM_BANKS-1:0] bank_ready;

   // banks to merger
   logic [NUM_BANKS-1:0] ep_valid;
   umi_packet_t          ep_packet [NUM_BANKS];
   logic [NUM_BANKS-1:0] ep_ready;

   //############################
   // request side
   //############################

   umi_req_router router0
      (
      .clk         (clk),
      .nreset      (nreset),
      .wr_valid    (wr_valid),
      .wr_packet   (wr_packet),
      .wr_ready    (wr_ready),
      .req_valid   (req_valid),
      .req_packet  (req_packet),
      .req_ready   (req_ready),
      .bank_valid  (bank_valid),
      .bank_packet (bank_packet),
      .bank_ready  (bank_ready)
      );

   //############################
   // banks
   //############################

   for (genvar i = 0; i < NUM_BANKS; i++)
   begin : g_bank
      umi_endpoint ep
         (
         .clk        (clk),
         .nreset     (nreset),
         .in_valid   (bank_valid[i]),
         .in_packet  (bank_packet),
         .in_ready   (bank_ready[i]),
         .out_valid  (ep_valid[i]),
         .out_packet (ep_packet[i]),
         .out_ready  (ep_ready[i])
         );
   end

   //############################
   // response side
   //############################

   umi_resp_merge merge0
      (
      .clk         (clk),
      .nreset      (nreset),
      .ep_valid    (ep_valid),
      .ep_packet   (ep_packet),
      .ep_ready    (ep_ready),
      .resp_valid  (resp_valid),
      .resp_packet (resp_packet),
      .resp_ready  (resp_ready)
      );

endmodule

`default_nettype wire

// File: verification/umi_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module umi_mem_tb;

   import umi_pkg::*;

   localparam int MAX_TAGS    = 512;             // tag lives in srcaddr[8:0]
   localparam int PAIRS       = 16;              // test 3 write/read pairs
   localparam int RAND_STEPS  = 100;             // test 4 transactions
   localparam int NUM_TRANS   = 2*NUM_BANKS*WORDS + 2*PAIRS + RAND_STEPS + 6;
   localparam int CYCLE_LIMIT = 40*NUM_TRANS + 100;
   localparam umi_cmd_t CMD_BOGUS = 7'h55;       // not a known command
   localparam umi_size_t REQ_SIZE = 4'h2;        // word, carried only

   logic        clk;
   logic        nreset;
   logic        wr_valid;
   umi_packet_t wr_packet;
   logic        wr_ready;
   logic        req_valid;
   umi_packet_t req_packet;
   logic        req_ready;
   logic        resp_valid;
   umi_packet_t resp_packet;
   logic        resp_ready;

   // reference model and read bookkeeping
   umi_data_t model [NUM_BANKS*WORDS];           // bank major, word minor
   logic      issued [MAX_TAGS];                 // written by stimulus only
   umi_data_t exp_data [MAX_TAGS];
   int        seen [MAX_TAGS];                   // written by monitor only
   int        next_tag;
   int        reads_issued;
   int        resp_count;
   int        errors;
   int        tests_pass;
   int        tests_fail;
   int        cycles;
   integer    seed = 4094;
   logic      check_idle;                        // test 1 window
   logic      back_pressure;                     // random resp_ready

   logic       resp_fire;
   logic [8:0] resp_tag;
   logic       tag_known;
   umi_data_t  exp_word;
   umi_opt_t   exp_opt;
   int         seen_now;

   umi_mem_top dut0
      (
      .clk         (clk),
      .nreset      (nreset),
      .wr_valid    (wr_valid),
      .wr_packet   (wr_packet),
      .wr_ready    (wr_ready),
      .req_valid   (req_valid),
      .req_packet  (req_packet),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_packet (resp_packet),
      .resp_ready  (resp_ready)
      );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;                     // 8 ns period
   end

   //############################
   // response monitor and checks
   //############################

   assign resp_fire = resp_valid & resp_ready;
   assign resp_tag  = resp_packet.dstaddr[8:0];
   assign tag_known = (resp_packet.dstaddr[ADDR_W-1:9] == '0) && issued[resp_tag];
   assign exp_word  = exp_data[resp_tag];
   assign exp_opt   = tag_options(resp_tag);
   assign seen_now  = seen[resp_tag];

   always @(posedge clk)
   begin
      if (nreset && resp_fire && resp_packet.dstaddr[ADDR_W-1:9] == '0)
      begin
         seen[resp_tag] <= seen[resp_tag] + 1;
         resp_count     <= resp_count + 1;
      end
   end

   a_idle_after_reset : assert property (@(posedge clk) disable iff (!nreset)
      check_idle |-> !resp_valid && wr_ready && req_ready)
   else
   begin
      errors++;
      $display("[FAIL] resp_valid/wr_ready/req_ready expected 0/1/1 got %h/%h/%h",
               $sampled(resp_valid), $sampled(wr_ready), $sampled(req_ready));
   end

   a_resp_cmd : assert property (@(posedge clk) disable iff (!nreset)
      resp_valid |-> resp_packet.cmd == CMD_RESP)
   else
   begin
      errors++;
      $display("[FAIL] resp_packet.cmd expected %h got %h", CMD_RESP,
               $sampled(resp_packet.cmd));
   end

   a_known_tag : assert property (@(posedge clk) disable iff (!nreset)
      resp_fire |-> tag_known)
   else
   begin
      errors++;
      $display("stray response to %h matches no read that was sent",
               $sampled(resp_packet.dstaddr));
   end

   a_single_resp : assert property (@(posedge clk) disable iff (!nreset)
      resp_fire |-> seen_now == 0)
   else
   begin
      errors++;
      $display("read tag %0d answered more than once", $sampled(resp_tag));
   end

   a_resp_data : assert property (@(posedge clk) disable iff (!nreset)
      resp_fire && tag_known |-> resp_packet.data == exp_word)
   else
   begin
      errors++;
      $display("[FAIL] resp_packet.data tag %0d expected %h got %h", $sampled(resp_tag),
               $sampled(exp_word), $sampled(resp_packet.data));
   end

   // size and options come back as sent, srcaddr is cleared
   a_resp_fields : assert property (@(posedge clk) disable iff (!nreset)
      resp_fire && tag_known |-> resp_packet.srcaddr == '0 &&
         resp_packet.size == REQ_SIZE && resp_packet.options == exp_opt)
   else
   begin
      errors++;
      $display("[FAIL] resp_packet size/options/srcaddr expected %h/%h/%h got %h/%h/%h",
               REQ_SIZE, $sampled(exp_opt), 32'h0, $sampled(resp_packet.size),
               $sampled(resp_packet.options), $sampled(resp_packet.srcaddr));
   end

   // stalled response must wait unchanged
   a_resp_stable : assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_packet))
   else
   begin
      errors++;
      $display("response was dropped or changed while resp_ready was low");
   end

   //############################
   // helpers
   //############################

   function automatic umi_addr_t bank_word_addr(input int bank, input int word);
      umi_addr_t a;
      a = '0;
      a[BANK_LSB +: BANK_W] = bank[BANK_W-1:0];
      a[WORD_LSB +: WORD_W] = word[WORD_W-1:0];
      return a;
   endfunction

   function automatic logic [BANK_W+WORD_W-1:0] model_index(input umi_addr_t addr);
      return {addr[BANK_LSB +: BANK_W], addr[WORD_LSB +: WORD_W]};   // high bits alias
   endfunction

   function automatic umi_data_t fill_word(input umi_addr_t addr);
      return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
   endfunction

   // options differ per tag so a copied field can be told apart
   function automatic umi_opt_t tag_options(input logic [8:0] tag);
      return {tag, 11'h35a};
   endfunction

   function automatic umi_packet_t make_packet(input umi_cmd_t cmd, input umi_addr_t dst,
                                               input umi_addr_t src, input umi_data_t data);
      umi_packet_t p;
      p.cmd     = cmd;
      p.size    = REQ_SIZE;
      p.options = tag_options(src[8:0]);
      p.dstaddr = dst;
      p.srcaddr = src;
      p.data    = data;
      return p;
   endfunction

   task automatic settle(input int n);
      repeat (n) @(negedge clk);
   endtask

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic push_write(input umi_cmd_t cmd, input umi_addr_t addr, input umi_data_t data);
      if (cmd == CMD_WRITE)
         model[model_index(addr)] = data;        // model follows at issue time
      wr_packet = make_packet(cmd, addr, '0, data);
      wr_valid  = 1'b1;
      #1;
      while (!wr_ready)
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      wr_valid = 1'b0;
   endtask

   task automatic push_read(input umi_cmd_t cmd, input umi_addr_t addr);
      if (cmd == CMD_READ)
      begin
         issued[next_tag]   = 1'b1;
         exp_data[next_tag] = model[model_index(addr)];
         reads_issued++;
      end
      req_packet = make_packet(cmd, addr, umi_addr_t'(next_tag), 32'h0);
      next_tag++;                                // bogus commands burn a tag too
      req_valid  = 1'b1;
      #1;
      while (!req_ready)
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic wait_responses();
      int waited;
      waited = 0;
      while (resp_count != reads_issued && waited < 400)
      begin
         @(negedge clk);
         waited++;
      end
      settle(4);                                 // room for a late stray
   endtask

   task automatic check_missing(input int first_tag);
      for (int t = first_tag; t < next_tag; t++)
         if (issued[t] && seen[t] == 0)
         begin
            errors++;
            $display("read tag %0d never got a response", t);
         end
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (errors == errs_before)
      begin
         tests_pass++;
         $display("test %s: pass", name);
      end
      else
      begin
         tests_fail++;
         $display("test %s: fail, %0d errors", name, errors - errs_before);
      end
   endtask

   //############################
   // back-pressure and timeout
   //############################

   initial
   begin
      logic [31:0] rnd;
      resp_ready = 1'b1;
      forever
      begin
         @(negedge clk);
         rnd = $random(seed);
         resp_ready = back_pressure ? |rnd[1:0] : 1'b1;   // ready 3 of 4 cycles
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, traffic did not complete", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   //############################
   // tests
   //############################

   initial
   begin
      int          errs;
      int          first;
      logic [31:0] rnd;
      umi_addr_t   addr;
      umi_addr_t   base;
      logic        dirty;
      nreset        = 1'b0;
      wr_valid      = 1'b0;
      wr_packet     = '0;
      req_valid     = 1'b0;
      req_packet    = '0;
      check_idle    = 1'b0;
      back_pressure = 1'b0;
      next_tag      = 0;
      reads_issued  = 0;
      errors        = 0;
      tests_pass    = 0;
      tests_fail    = 0;
      dirty         = 1'b0;
      for (int i = 0; i < MAX_TAGS; i++)
      begin
         issued[i]   = 1'b0;
         exp_data[i] = '0;
      end
      for (int i = 0; i < NUM_BANKS*WORDS; i++)
         model[i] = '0;
      repeat (3) @(negedge clk);
      nreset = 1'b1;

      // 1: quiet bus straight after reset
      errs = errors;
      check_idle = 1'b1;
      settle(5);
      check_idle = 1'b0;
      end_test("1 reset state", errs);

      // 2: every word of every bank
      errs  = errors;
      first = next_tag;
      for (int b = 0; b < NUM_BANKS; b++)
         for (int w = 0; w < WORDS; w++)
         begin
            addr = bank_word_addr(b, w);
            push_write(CMD_WRITE, addr, fill_word(addr));
            settle(4);
            push_read(CMD_READ, addr);
         end
      wait_responses();
      check_missing(first);
      end_test("2 write/read sweep", errs);

      // 3: both channels offered together, read bank two away from write bank
      errs  = errors;
      first = next_tag;
      for (int k = 0; k < PAIRS; k++)
      begin
         rnd = $random(seed);
         fork
            push_write(CMD_WRITE, bank_word_addr(k % NUM_BANKS, int'(rnd[3:0])),
                       $random(seed));
            push_read(CMD_READ, bank_word_addr((k + 2) % NUM_BANKS, int'(rnd[7:4])));
         join
         settle(4);
      end
      wait_responses();
      check_missing(first);
      end_test("3 concurrent channels", errs);

      // 4: random mix, full random addresses alias down
      errs  = errors;
      first = next_tag;
      back_pressure = 1'b1;
      for (int s = 0; s < RAND_STEPS; s++)
      begin
         rnd  = $random(seed);
         addr = $random(seed);
         if (rnd[0])
         begin
            push_write(CMD_WRITE, addr, $random(seed));
            dirty = 1'b1;
         end
         else
         begin
            if (dirty)
               settle(4);                        // let the write land first
            dirty = 1'b0;
            push_read(CMD_READ, addr);
         end
      end
      wait_responses();
      back_pressure = 1'b0;
      check_missing(first);
      end_test("4 random with back-pressure", errs);

      // 5: aliasing and unknown commands
      errs  = errors;
      first = next_tag;
      base  = bank_word_addr(2, 9);
      addr  = base | 32'habc0_0000;
      push_write(CMD_WRITE, addr, fill_word(addr));
      settle(4);
      push_read(CMD_READ, base | 32'h0000_3f03); // other high bits and byte lane
      push_write(CMD_BOGUS, base, 32'hdead_beef); // must leave the word alone
      settle(4);
      push_read(CMD_READ, base);
      push_read(CMD_BOGUS, base);                // no answer allowed
      wait_responses();
      check_missing(first);
      end_test("5 alias and unknown command", errs);

      $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
      if (tests_fail == 0 && errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
verilog/umi_pkg.sv
verilog/umi_req_router.sv
verilog/umi_endpoint.sv
verilog/umi_resp_merge.sv
verilog/umi_mem_top.sv
verification/umi_mem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the banked memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module umi_mem_tb -f compile.f

status=0
out=$(./obj_dir/Vumi_mem_tb 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
